/* verilog/fetchPkg.sv */
/*
 Shared constants and types for the 16-bit fetch and decode front end.
 Modules import it inside their bodies and use scoped names on ports.
*/
package fetchPkg;

    localparam int instrWidth = 16;    // Instruction and PC width
    localparam int imemDepth = 256;    // Words
    localparam int imemAddrWidth = 8;  // Word address
    localparam int queueDepth = 2;
    localparam int queueCountWidth = 2;

    // Opcodes live in bits 15:11
    localparam logic [4:0] opHalt = 5'b00000;
    localparam logic [4:0] opNop = 5'b00001;
    localparam logic [4:0] opJ = 5'b00100;
    localparam logic [4:0] opJr = 5'b00101;
    localparam logic [4:0] opJal = 5'b00110;
    localparam logic [4:0] opJalr = 5'b00111;
    localparam logic [4:0] opAddi = 5'b01000;
    localparam logic [4:0] opSubi = 5'b01001;
    localparam logic [4:0] opXori = 5'b01010;
    localparam logic [4:0] opAndni = 5'b01011;
    localparam logic [4:0] opBeqz = 5'b01100;
    localparam logic [4:0] opBnez = 5'b01101;
    localparam logic [4:0] opBltz = 5'b01110;
    localparam logic [4:0] opBgez = 5'b01111;
    localparam logic [4:0] opSt = 5'b10000;
    localparam logic [4:0] opLd = 5'b10001;
    localparam logic [4:0] opSlbi = 5'b10010;
    localparam logic [4:0] opStu = 5'b10011;
    localparam logic [4:0] opRoli = 5'b10100;
    localparam logic [4:0] opSlli = 5'b10101;
    localparam logic [4:0] opRori = 5'b10110;
    localparam logic [4:0] opSrli = 5'b10111;
    localparam logic [4:0] opLbi = 5'b11000;
    localparam logic [4:0] opBtr = 5'b11001;
    localparam logic [4:0] opShiftRr = 5'b11010; // ROL, SLL, ROR, SRL by func
    localparam logic [4:0] opAluRr = 5'b11011;   // ADD, SUB, XOR, ANDN by func
    localparam logic [4:0] opSeq = 5'b11100;
    localparam logic [4:0] opSlt = 5'b11101;
    localparam logic [4:0] opSle = 5'b11110;
    localparam logic [4:0] opSco = 5'b11111;

    localparam logic [instrWidth-1:0] nopWord = 16'h0800; // Load-use bubble

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmt_s;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFmt_s;

    // Same word, seen as R-format or I-format
    typedef union packed {
        rFmt_s r;
        iFmt_s i;
    } instrWord_u;

    typedef struct packed {
        logic [instrWidth-1:0] pc;
        instrWord_u instr;
    } fetchItem_s;

    typedef enum logic [1:0] {
        rsDest = 2'b00,
        rdR = 2'b01,
        linkR7 = 2'b10,
        rdI = 2'b11
    } destSel_e;

    /* immSel: 000 zext5, 001 sext5, 010 sext8, 011 zext8, 100 sext11
       linkReg: 00 ALU result, 01 PC+2, 10 immediate, 11 SLBI merge */
    typedef struct packed {
        logic regWrite;
        logic [2:0] destReg;
        logic memEnable;
        logic memWr;
        logic val2Reg;   // Write back memory data
        logic aluSel;    // ALU B takes the immediate
        logic [2:0] immSel;
        logic [1:0] linkReg;
        logic bFlag;
        logic jFlag;
        logic halt;
        logic ctrlErr;
    } ctrl_s;

    typedef struct packed {
        logic [instrWidth-1:0] pc;
        logic [4:0] opcode;
        ctrl_s ctrl;
    } decodeOut_s;

endpackage

/* verilog/instrMem.sv */
/*
 Instruction memory. Loaded word by word through an APB slave port
 before the run; fetch reads it through a one-cycle synchronous port.
*/
`timescale 1ns/1ps
module instrMem (
    input  logic clk,
    input  logic arstN,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [fetchPkg::imemAddrWidth:0] paddr, // Top bit lies past the array
    input  logic [fetchPkg::instrWidth-1:0] pwdata,
    output logic pready,
    output logic pslverr,
    input  logic run,
    input  logic rdEn,
    input  logic [fetchPkg::imemAddrWidth-1:0] rdAddr,
    output logic [fetchPkg::instrWidth-1:0] rdData
);
    import fetchPkg::*;

    logic [instrWidth-1:0] mem [imemDepth];
    logic access;
    logic badAddr;

    assign access = psel && penable;
    assign badAddr = paddr >= (imemAddrWidth + 1)'(imemDepth);

    // No wait states
    assign pready = access;
    assign pslverr = access && (badAddr || (pwrite && run)); // No loading while running

    always_ff @(posedge clk) begin
        if (access && pwrite && !pslverr) begin
            mem[paddr[imemAddrWidth-1:0]] <= pwdata;
        end
    end

    // Fetch port, data one clock after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    // Every access phase follows a setup phase
    apbSetupFirst: assert property (@(posedge clk) disable iff (!arstN)
        penable |-> psel && $past(psel && !penable))
        else $error("APB access phase without setup phase");

endmodule

/* verilog/fetchUnit.sv */
/*
 Program counter and fetch request logic. Issues one read per cycle
 while running and while the queue can take the word, counting the
 word in flight. Redirect reloads the PC and drops the returning word.
*/
`timescale 1ns/1ps
module fetchUnit (
    input  logic clk,
    input  logic arstN,
    input  logic run,
    input  logic queueFull,
    input  logic [fetchPkg::queueCountWidth-1:0] queueCount,
    input  logic redirect,
    input  logic [fetchPkg::instrWidth-1:0] redirectPc,
    input  logic haltSeen,
    output logic rdEn,
    output logic [fetchPkg::imemAddrWidth-1:0] rdAddr,
    input  logic [fetchPkg::instrWidth-1:0] rdData,
    output logic push,
    output fetchPkg::fetchItem_s pushItem
);
    import fetchPkg::*;

    logic [instrWidth-1:0] pc;        // Byte address, word aligned
    logic [instrWidth-1:0] flightPc;
    logic inFlight;
    logic [queueCountWidth:0] used;   // Queue entries plus word in flight

    assign used = {1'b0, queueCount} + (queueCountWidth + 1)'(inFlight);

    assign rdEn = run && !haltSeen && !redirect && !queueFull
                  && (used < (queueCountWidth + 1)'(queueDepth));
    assign rdAddr = pc[imemAddrWidth:1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            inFlight <= 1'b0;
        end else begin
            inFlight <= rdEn;
            if (redirect) begin
                pc <= redirectPc;
            end else if (rdEn) begin
                pc <= pc + instrWidth'(2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            flightPc <= pc;
        end
    end

    // Word returning during a redirect belongs to the old path
    assign push = inFlight && !redirect;
    assign pushItem.pc = flightPc;
    assign pushItem.instr = rdData;

    noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        push |-> !queueFull)
        else $error("Fetch pushed into a full queue");

endmodule

/* verilog/fetchQueue.sv */
/*
 Two-entry fetch queue of PC and instruction pairs. A pushed item is
 at the head the next cycle. Flush empties it in one cycle.
*/
`timescale 1ns/1ps
module fetchQueue (
    input  logic clk,
    input  logic arstN,
    input  logic push,
    input  fetchPkg::fetchItem_s pushItem,
    input  logic flush,
    input  logic pop,
    output logic headValid,
    output fetchPkg::fetchItem_s headItem,
    output logic full,
    output logic [fetchPkg::queueCountWidth-1:0] count
);
    import fetchPkg::*;

    fetchItem_s slots [queueDepth];
    logic [$clog2(queueDepth)-1:0] wrPtr;
    logic [$clog2(queueDepth)-1:0] rdPtr;
    logic doPush;
    logic doPop;

    assign headValid = count != '0;
    assign full = count == queueCountWidth'(queueDepth);
    assign headItem = slots[rdPtr];

    assign doPush = push && !full;
    assign doPop = pop && headValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1; // Wraps at queueDepth
            if (doPop) rdPtr <= rdPtr + 1'b1;
            count <= count + queueCountWidth'(doPush) - queueCountWidth'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= pushItem;
        end
    end

    // Decode must only take a valid head
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
        pop |-> headValid)
        else $error("Pop from an empty fetch queue");

endmodule

/* verilog/instrDecode.sv */
/*
 Decode stage. Turns the queue head into a registered control record,
 inserts one NOP bubble on a load-use hazard and flags halt to fetch.
 A record shown in the same cycle as redirect is squashed.
*/
`timescale 1ns/1ps
module instrDecode (
    input  logic clk,
    input  logic arstN,
    input  logic headValid,
    input  fetchPkg::fetchItem_s headItem,
    output logic pop,
    input  logic exStall,
    input  logic redirect,
    output logic outValid,
    output fetchPkg::decodeOut_s outRec,
    output logic haltSeen
);
    import fetchPkg::*;

    instrWord_u head;
    instrWord_u dec;
    logic [4:0] op;
    ctrl_s ctrl;
    destSel_e dSel;
    logic usesRs;
    logic usesRt;
    logic hazard;
    logic issue;
    logic loadPending;     // Last issued record was a load
    logic [2:0] loadDest;

    assign head = headItem.instr;
    assign usesRs = !(head.r.opcode inside {opHalt, opNop, opJ, opJal, opLbi});
    assign usesRt = head.r.opcode inside {opSt, opStu, opAluRr, opShiftRr,
                                          opSeq, opSlt, opSle, opSco};
    assign hazard = loadPending && ((usesRs && head.r.rs == loadDest)
                                    || (usesRt && head.r.rt == loadDest));

    assign dec = hazard ? instrWord_u'(nopWord) : head;
    assign op = dec.r.opcode;

    assign issue = headValid && !exStall && !redirect && !haltSeen;
    assign pop = issue && !hazard; // Dependent instruction waits out the bubble

    always_comb begin
        ctrl = '0;
        dSel = rsDest;
        case (op)
            opHalt: ctrl.halt = 1'b1;
            opNop: ctrl.halt = 1'b0;
            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel = 1'b1;
                ctrl.immSel = (op == opAddi || op == opSubi) ? 3'b001 : 3'b000;
                dSel = rdI;
            end
            opSt, opStu, opLd: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr = op != opLd;
                ctrl.val2Reg = op == opLd;
                ctrl.regWrite = op != opSt; // STU writes back the address
                ctrl.aluSel = 1'b1;
                ctrl.immSel = 3'b001;
                dSel = (op == opLd) ? rdI : rsDest;
            end
            opBtr, opAluRr, opShiftRr, opSeq, opSlt, opSle, opSco: begin
                ctrl.regWrite = 1'b1;
                dSel = rdR;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrl.bFlag = 1'b1;
                ctrl.immSel = 3'b010;
            end
            opLbi, opSlbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSel = (op == opLbi) ? 3'b010 : 3'b011;
                ctrl.linkReg = (op == opLbi) ? 2'b10 : 2'b11;
            end
            opJ, opJr, opJal, opJalr: begin
                ctrl.jFlag = 1'b1;
                ctrl.immSel = op[0] ? 3'b010 : 3'b100; // Register forms use 8 bits
                ctrl.regWrite = op[1];                 // JAL and JALR link
                ctrl.linkReg = op[1] ? 2'b01 : 2'b00;
                dSel = linkR7;
            end
            default: ctrl.ctrlErr = 1'b1;
        endcase
        case (dSel)
            rsDest: ctrl.destReg = dec.r.rs;
            rdR: ctrl.destReg = dec.r.rd;
            linkR7: ctrl.destReg = 3'd7;
            default: ctrl.destReg = dec.i.rd;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            loadPending <= 1'b0;
            haltSeen <= 1'b0;
        end else if (redirect) begin
            outValid <= 1'b0;
            loadPending <= 1'b0;
            haltSeen <= 1'b0; // Halt on the squashed path
        end else if (!exStall) begin
            outValid <= issue;
            if (issue) begin
                loadPending <= ctrl.memEnable && ctrl.val2Reg;
                haltSeen <= ctrl.halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            outRec.pc <= headItem.pc;
            outRec.opcode <= op;
            outRec.ctrl <= ctrl;
            loadDest <= ctrl.destReg;
        end
    end

    squashAfterRedirect: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> ##2 !outValid)
        else $error("Record issued right after a redirect");

endmodule

/* verilog/fetchTop.sv */
/*
 Front end top level. Load the program over APB, then raise run.
 Decoded records leave on outRec marked by outValid; the execute side
 drives exStall and the redirect pulse with its target.
*/
`timescale 1ns/1ps
module fetchTop (
    input  logic clk,
    input  logic arstN,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [fetchPkg::imemAddrWidth:0] paddr,
    input  logic [fetchPkg::instrWidth-1:0] pwdata,
    output logic pready,
    output logic pslverr,
    input  logic run,
    input  logic exStall,
    input  logic redirect,
    input  logic [fetchPkg::instrWidth-1:0] redirectPc,
    output logic outValid,
    output fetchPkg::decodeOut_s outRec
);
    import fetchPkg::*;

    logic rdEn;
    logic [imemAddrWidth-1:0] rdAddr;
    logic [instrWidth-1:0] rdData;
    logic push;
    fetchItem_s pushItem;
    logic queueFull;
    logic [queueCountWidth-1:0] queueCount;
    logic headValid;
    fetchItem_s headItem;
    logic pop;
    logic haltSeen;

    instrMem u_mem (
        .clk(clk), .arstN(arstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .pslverr(pslverr), .run(run),
        .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData)
    );

    fetchUnit u_fetch (
        .clk(clk), .arstN(arstN), .run(run),
        .queueFull(queueFull), .queueCount(queueCount),
        .redirect(redirect), .redirectPc(redirectPc), .haltSeen(haltSeen),
        .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData),
        .push(push), .pushItem(pushItem)
    );

    fetchQueue u_queue (
        .clk(clk), .arstN(arstN), .push(push), .pushItem(pushItem),
        .flush(redirect), .pop(pop), .headValid(headValid), .headItem(headItem),
        .full(queueFull), .count(queueCount)
    );

    instrDecode u_decode (
        .clk(clk), .arstN(arstN), .headValid(headValid), .headItem(headItem), .pop(pop),
        .exStall(exStall), .redirect(redirect),
        .outValid(outValid), .outRec(outRec), .haltSeen(haltSeen)
    );

endmodule

/* testbench/fetchTb.sv */
/*
 Testbench for the fetch and decode front end. Loads the program over
 APB from the stimulus file, runs it under random exStall with redirects
 taken from the expected list, and compares each decoded record in order.
*/
`timescale 1ns/1ps
module fetchTb;
    import fetchPkg::*;

    localparam int progBase = 'h008;    // Word offsets in the stimulus file
    localparam int recBase = 'h100;
    localparam int recWords = 9;
    localparam int quietCycles = 40;    // Silence checked after halt

    logic clk = 1'b0;
    logic arstN;
    logic psel;
    logic penable;
    logic pwrite;
    logic [imemAddrWidth:0] paddr;
    logic [instrWidth-1:0] pwdata;
    logic pready;
    logic pslverr;
    logic run;
    logic exStall;
    logic redirect;
    logic [instrWidth-1:0] redirectPc;
    logic outValid;
    decodeOut_s outRec;

    logic [15:0] stim [0:511];
    int progLen;
    int recCount;
    int recIdx = 0;
    bit loaded = 1'b0;
    int errCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testStartErrors;
    logic [31:0] lfsr = 32'hd0cc3ab1;
    logic [15:0] lastTarget = '0;

    fetchTop u_dut (
        .clk(clk), .arstN(arstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .pslverr(pslverr), .run(run), .exStall(exStall),
        .redirect(redirect), .redirectPc(redirectPc),
        .outValid(outValid), .outRec(outRec)
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic logic [15:0] stimAt(input int addr);
        return stim[9'(addr)];
    endfunction

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic reportError(input string msg);
        errCount++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic startTest();
        testStartErrors = errCount;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errCount != testStartErrors) begin
            testsFailed++;
            $display("Test %s: FAIL, %0d errors", name, errCount - testStartErrors);
        end else begin
            $display("Test %s: PASS", name);
        end
    endtask

    task automatic apbWrite(input logic [imemAddrWidth:0] addr, input logic [15:0] data,
                            output logic ready, output logic err);
        @(posedge clk);
        psel <= 1'b1;       // Setup phase
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;    // Access phase
        @(negedge clk);
        ready = pready;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    // Compare the record on outRec with expected record n
    task automatic checkRecord(input int n, output logic [15:0] target);
        int base;
        logic [4:0] expFlags;
        logic [4:0] gotFlags;
        base = recBase + recWords * n;
        expFlags = {stimAt(base + 3) != '0, stimAt(base + 4) != '0, stimAt(base + 5) != '0,
                    stimAt(base + 6) != '0, stimAt(base + 7) != '0};
        gotFlags = {outRec.ctrl.regWrite, outRec.ctrl.memEnable, outRec.ctrl.memWr,
                    outRec.ctrl.halt, outRec.ctrl.ctrlErr};
        target = stimAt(base + 8);
        if (outRec.pc !== stimAt(base)) begin
            reportError($sformatf("record %0d pc %h, expected %h", n, outRec.pc, stimAt(base)));
        end
        if (outRec.opcode !== 5'(stimAt(base + 1))) begin
            reportError($sformatf("record %0d opcode %h, expected %h", n, outRec.opcode,
                                  5'(stimAt(base + 1))));
        end
        if (outRec.ctrl.destReg !== 3'(stimAt(base + 2))) begin
            reportError($sformatf("record %0d destReg %0d, expected %0d", n,
                                  outRec.ctrl.destReg, 3'(stimAt(base + 2))));
        end
        if (gotFlags !== expFlags) begin
            reportError($sformatf("record %0d flags %b, expected %b", n, gotFlags, expFlags));
        end
        if (lastTarget != '0 && outRec.pc !== lastTarget) begin
            reportError($sformatf("record %0d pc %h is not the redirect target %h", n,
                                  outRec.pc, lastTarget));
        end
        lastTarget = target;
    endtask

    initial begin
        logic ready;
        logic err;
        logic takeRec;
        logic holding;
        logic [15:0] pendTarget;
        decodeOut_s heldRec;
        arstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        run = 1'b0;
        exStall = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        $readmemh("testbench/fetch_stimulus.txt", stim);
        progLen = int'(stim[0]);
        recCount = int'(stim[1]);
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        startTest();
        @(negedge clk);
        if (outValid !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0) begin
            reportError("outValid, pready or pslverr not low after reset");
        end
        endTest("reset state");

        startTest();
        for (int i = 0; i < progLen; i++) begin
            apbWrite(9'(i), stimAt(progBase + i), ready, err);
            if (ready !== 1'b1 || err !== 1'b0) begin
                reportError($sformatf("APB write to word %0d gave pready %b pslverr %b",
                                      i, ready, err));
            end
        end
        apbWrite(9'(imemDepth), 16'hffff, ready, err);
        if (ready !== 1'b1 || err !== 1'b1) begin
            reportError($sformatf("out of range APB write gave pready %b pslverr %b", ready, err));
        end
        endTest("APB load");

        startTest();
        holding = 1'b0;
        @(posedge clk);
        run <= 1'b1;
        while (recIdx < recCount) begin
            @(negedge clk);
            if (holding && (outValid !== 1'b1 || outRec !== heldRec)) begin
                reportError("decode output changed while exStall was high");
            end
            takeRec = outValid && !exStall && !redirect; // Squashed during redirect
            holding = outValid && exStall && !redirect;
            heldRec = outRec;
            pendTarget = '0;
            if (takeRec) begin
                checkRecord(recIdx, pendTarget);
                recIdx++;
            end
            @(posedge clk);
            lfsr = lfsrStep(lfsr);
            exStall <= lfsr[0];
            redirect <= pendTarget != '0;
            redirectPc <= pendTarget;
        end
        endTest("decode run with stalls and redirects");

        startTest();
        repeat (quietCycles) begin
            @(negedge clk);
            if (outValid !== 1'b0) begin
                reportError($sformatf("outValid after the halt record, pc %h", outRec.pc));
            end
        end
        endTest("halt");

        startTest();
        apbWrite(9'd0, 16'hffff, ready, err);
        if (ready !== 1'b1 || err !== 1'b1) begin
            reportError($sformatf("APB write while running gave pready %b pslverr %b",
                                  ready, err));
        end
        endTest("APB write while running");

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded);
        repeat (40 * progLen + 200) @(posedge clk);
        $display("Timeout: the halt record never came, %0d of %0d records were checked",
                 recIdx, recCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* testbench/fetch_stimulus.txt */
// Front end stimulus for $readmemh, all values hex
// @000 holds the program word count and the expected record count
@000
001C 0012
// @008 holds the program words, one per word address from zero
@008
4025 8940 DA2C 8982 51A3 8181 88C4 81C0
1000 2006 47FF 47FF 47FF 47FF 47FF 47FF
3003 47FF 47FF 47FF C312 6304 6B02 47FF
47FF E354 0000 47FF
// @100 holds the expected records, one per line
// pc opcode destReg regWrite memEnable memWr halt ctrlErr redirectTarget
@100
0000 08 1 1 0 0 0 0 0000
0002 11 2 1 1 0 0 0 0000
0004 01 0 0 0 0 0 0 0000
0004 1B 3 1 0 0 0 0 0000
0006 11 4 1 1 0 0 0 0000
0008 0A 5 1 0 0 0 0 0000
000A 10 1 0 1 1 0 0 0000
000C 11 6 1 1 0 0 0 0000
000E 01 0 0 0 0 0 0 0000
000E 10 1 0 1 1 0 0 0000
0010 02 0 0 0 0 0 1 0000
0012 04 7 0 0 0 0 0 0020
0020 06 7 1 0 0 0 0 0028
0028 18 3 1 0 0 0 0 0000
002A 0C 3 0 0 0 0 0 0000
002C 0D 3 0 0 0 0 0 0032
0032 1C 5 1 0 0 0 0 0000
0034 00 0 0 0 0 1 0 0000

/* src.f */
verilog/fetchPkg.sv
verilog/instrMem.sv
verilog/fetchUnit.sv
verilog/fetchQueue.sv
verilog/instrDecode.sv
verilog/fetchTop.sv
testbench/fetchTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the front end testbench with Verilator and run it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module fetchTb -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VfetchTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
